// ==== hw/ldq_alloc.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldq_cfg.svh"

module ldq_alloc
    import ldq_pkg::*;
(
    input  wire                           clk,
    input  wire                           rst_n,

    input  wire                           load_vld,
    input  wire mem_addr_t                load_addr,
    input  wire load_op_e                 load_op,
    input  wire reg_idx_t                 load_rd,
    input  wire                           cancel_en,

    input  wire entry_id_t                issue_id,
    input  wire entry_id_t                ack_tag,

    output entry_id_t                     wr_ptr,
    output mem_addr_t                     issue_addr,
    output logic [LINE_OFFSET_WIDTH-1:0]  ack_offset,
    output load_op_e                      ack_op,
    output reg_idx_t                      ack_rd
);

    mem_addr_t  entry_addr [`LDQ_DEPTH];
    load_op_e   entry_op   [`LDQ_DEPTH];
    reg_idx_t   entry_rd   [`LDQ_DEPTH];

    // ========================================================================
    // write pointer
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
        end
        else if (cancel_en) begin
            wr_ptr <= '0;
        end
        else if (load_vld) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // ========================================================================
    // payload storage
    // ========================================================================
    always_ff @(posedge clk) begin
        if (load_vld) begin
            entry_addr[wr_ptr] <= load_addr;
            entry_op[wr_ptr]   <= load_op;
            entry_rd[wr_ptr]   <= load_rd;
        end
    end

    // request side read port
    assign issue_addr = entry_addr[issue_id];

    // ack side read port, only the line offset of the address is needed
    assign ack_offset = entry_addr[ack_tag][LINE_OFFSET_WIDTH-1:0];
    assign ack_op     = entry_op[ack_tag];
    assign ack_rd     = entry_rd[ack_tag];

endmodule

`default_nettype wire

// ==== hw/ldq_cfg.svh ====
`ifndef LDQ_CFG_SVH
`define LDQ_CFG_SVH

// queue size, also the number of credits after reset or cancel
`define LDQ_DEPTH 8

// load address width
`define LDQ_ADDR_WIDTH 32

// physical register index width
`define LDQ_REG_IDX_WIDTH 6

// writeback value width
`define LDQ_REG_WIDTH 32

// bytes per memory ack line, low address bits give the offset
`define LDQ_LINE_BYTES 32

`endif

// ==== hw/ldq_issue.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldq_cfg.svh"

module ldq_issue
    import ldq_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,

    input  wire             load_vld,
    input  wire entry_id_t  wr_ptr,
    input  wire             cancel_en,

    input  wire             mem_req_rdy,
    input  wire             mem_ack_vld,
    input  wire entry_id_t  mem_ack_tag,

    output logic            mem_req_vld,
    output entry_id_t       issue_id,
    output logic            credit_en
);

    localparam int unsigned DEPTH = `LDQ_DEPTH;

    logic [DEPTH-1:0]   entry_vld;
    logic [DEPTH-1:0]   entry_req;
    logic [DEPTH-1:0]   entry_ack;
    logic [DEPTH-1:0]   pend_vec;
    entry_id_t          head_ptr;
    logic               issue_found;
    logic               issue_fire;
    logic               retire_en;

    // ========================================================================
    // issue selection
    // ========================================================================
    // valid entries still waiting for a request
    assign pend_vec = entry_vld & ~entry_req;

    // walk from the head so the oldest waiting entry wins
    always_comb begin
        issue_found = 1'b0;
        issue_id    = head_ptr;
        for (int k = 0; k < DEPTH; k++) begin
            if (!issue_found && pend_vec[entry_id_t'(head_ptr + k)]) begin
                issue_found = 1'b1;
                issue_id    = entry_id_t'(head_ptr + k);
            end
        end
    end

    assign mem_req_vld = issue_found;
    assign issue_fire  = mem_req_vld & mem_req_rdy;

    // ========================================================================
    // retirement
    // ========================================================================
    assign retire_en = entry_vld[head_ptr] & entry_ack[head_ptr];

    // nothing retires in a cancel cycle, the whole queue is dropped
    assign credit_en = retire_en & ~cancel_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head_ptr <= '0;
        end
        else if (cancel_en) begin
            head_ptr <= '0;
        end
        else if (retire_en) begin
            head_ptr <= head_ptr + 1'b1;
        end
    end

    // ========================================================================
    // per entry flags
    // ========================================================================
    for (genvar i = 0; i < DEPTH; i++) begin : g_entry

        logic is_head;

        assign is_head = (head_ptr == entry_id_t'(i));

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                entry_vld[i] <= 1'b0;
            end
            else if (cancel_en) begin
                entry_vld[i] <= 1'b0;
            end
            else if (load_vld && (wr_ptr == entry_id_t'(i))) begin
                entry_vld[i] <= 1'b1;
            end
            else if (retire_en && is_head) begin
                entry_vld[i] <= 1'b0;
            end
        end

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                entry_req[i] <= 1'b0;
            end
            else if (cancel_en) begin
                entry_req[i] <= 1'b0;
            end
            else if (issue_fire && (issue_id == entry_id_t'(i))) begin
                entry_req[i] <= 1'b1;
            end
            else if (retire_en && is_head) begin
                entry_req[i] <= 1'b0;
            end
        end

        // acks may come back in any order
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                entry_ack[i] <= 1'b0;
            end
            else if (cancel_en) begin
                entry_ack[i] <= 1'b0;
            end
            else if (mem_ack_vld && (mem_ack_tag == entry_id_t'(i))) begin
                entry_ack[i] <= 1'b1;
            end
            else if (retire_en && is_head) begin
                entry_ack[i] <= 1'b0;
            end
        end

    end

endmodule

`default_nettype wire

// ==== hw/ldq_load_align.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldq_cfg.svh"

module ldq_load_align
    import ldq_pkg::*;
(
    input  wire                                mem_ack_vld,
    input  wire line_data_t                    mem_ack_data,
    input  wire [LINE_OFFSET_WIDTH-1:0]        ack_offset,
    input  wire load_op_e                      ack_op,
    input  wire reg_idx_t                      ack_rd,

    output logic                               reg_wr_en,
    output reg_idx_t                           reg_index,
    output reg_val_t                           reg_val
);

    localparam int unsigned REG_W = `LDQ_REG_WIDTH;

    line_data_t shifted_data;

    // move the addressed byte down to bit 0
    assign shifted_data = mem_ack_data >> {ack_offset, 3'b000};

    always_comb begin
        case (ack_op)
            LB: begin
                reg_val = {{(REG_W-8){shifted_data[7]}}, shifted_data[7:0]};
            end
            LBU: begin
                reg_val = {{(REG_W-8){1'b0}}, shifted_data[7:0]};
            end
            LH: begin
                reg_val = {{(REG_W-16){shifted_data[15]}}, shifted_data[15:0]};
            end
            LHU: begin
                reg_val = {{(REG_W-16){1'b0}}, shifted_data[15:0]};
            end
            // LW and any unknown code take the full word
            default: begin
                reg_val = shifted_data[REG_W-1:0];
            end
        endcase
    end

    // every ack writes back in its own cycle
    assign reg_wr_en = mem_ack_vld;
    assign reg_index = ack_rd;

endmodule

`default_nettype wire

// ==== hw/ldq_pkg.sv ====
`default_nettype none

`include "ldq_cfg.svh"

package ldq_pkg;

    localparam int unsigned ENTRY_ID_WIDTH    = $clog2(`LDQ_DEPTH);
    localparam int unsigned LINE_OFFSET_WIDTH = $clog2(`LDQ_LINE_BYTES);

    // funct3 encodings of the RISC-V loads
    typedef enum logic [2:0] {
        LB  = 3'b000,
        LH  = 3'b001,
        LW  = 3'b010,
        LBU = 3'b100,
        LHU = 3'b101
    } load_op_e;

    // entry index, also used as the memory tag
    typedef logic [ENTRY_ID_WIDTH-1:0]        entry_id_t;
    typedef logic [`LDQ_ADDR_WIDTH-1:0]       mem_addr_t;
    typedef logic [`LDQ_REG_IDX_WIDTH-1:0]    reg_idx_t;
    typedef logic [`LDQ_REG_WIDTH-1:0]        reg_val_t;
    typedef logic [`LDQ_LINE_BYTES*8-1:0]     line_data_t;

endpackage

`default_nettype wire

// ==== hw/ldq_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldq_cfg.svh"

module ldq_top
    import ldq_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,

    // load input, credit based
    input  wire              load_vld,
    input  wire mem_addr_t   load_addr,
    input  wire load_op_e    load_op,
    input  wire reg_idx_t    load_rd,
    input  wire              cancel_en,
    output logic             credit_en,

    // memory request
    output logic             mem_req_vld,
    output mem_addr_t        mem_req_addr,
    output entry_id_t        mem_req_tag,
    input  wire              mem_req_rdy,

    // memory ack
    input  wire              mem_ack_vld,
    input  wire entry_id_t   mem_ack_tag,
    input  wire line_data_t  mem_ack_data,

    // register writeback
    output logic             reg_wr_en,
    output reg_idx_t         reg_index,
    output reg_val_t         reg_val
);

    entry_id_t                     wr_ptr;
    entry_id_t                     issue_id;
    mem_addr_t                     issue_addr;
    logic [LINE_OFFSET_WIDTH-1:0]  ack_offset;
    load_op_e                      ack_op;
    reg_idx_t                      ack_rd;

    assign mem_req_tag  = issue_id;
    assign mem_req_addr = issue_addr;

    ldq_alloc u_alloc (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_vld     (load_vld),
        .load_addr    (load_addr),
        .load_op      (load_op),
        .load_rd      (load_rd),
        .cancel_en    (cancel_en),
        .issue_id     (issue_id),
        .ack_tag      (mem_ack_tag),
        .wr_ptr       (wr_ptr),
        .issue_addr   (issue_addr),
        .ack_offset   (ack_offset),
        .ack_op       (ack_op),
        .ack_rd       (ack_rd)
    );

    ldq_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .load_vld     (load_vld),
        .wr_ptr       (wr_ptr),
        .cancel_en    (cancel_en),
        .mem_req_rdy  (mem_req_rdy),
        .mem_ack_vld  (mem_ack_vld),
        .mem_ack_tag  (mem_ack_tag),
        .mem_req_vld  (mem_req_vld),
        .issue_id     (issue_id),
        .credit_en    (credit_en)
    );

    ldq_load_align u_load_align (
        .mem_ack_vld  (mem_ack_vld),
        .mem_ack_data (mem_ack_data),
        .ack_offset   (ack_offset),
        .ack_op       (ack_op),
        .ack_rd       (ack_rd),
        .reg_wr_en    (reg_wr_en),
        .reg_index    (reg_index),
        .reg_val      (reg_val)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the load queue testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ldq_tb -f sim.f -o ldq_sim \
    && ./obj_dir/ldq_sim +verilator+error+limit+1000 > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log \
    && { echo "simulation FAILED"; exit 1; } \
    || { echo "simulation passed"; exit 0; }

// ==== sim.f ====
+incdir+hw
hw/ldq_pkg.sv
hw/ldq_alloc.sv
hw/ldq_issue.sv
hw/ldq_load_align.sv
hw/ldq_top.sv
test/ldq_checker.sv
test/ldq_tb.sv

// ==== test/ldq_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldq_cfg.svh"

module ldq_checker
    import ldq_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire             cancel_en,
    input  wire             credit_en,
    input  wire             mem_req_vld,
    input  wire             mem_req_rdy,
    input  wire entry_id_t  mem_req_tag,
    input  wire mem_addr_t  mem_req_addr,
    input  wire             mem_ack_vld,
    input  wire             reg_wr_en
);

    int                       stable_fails = 0;
    int                       reset_fails = 0;
    int                       ack_fails = 0;
    int                       fail_total;
    logic [ENTRY_ID_WIDTH:0]  outstanding;
    logic                     req_fire;

    assign fail_total = stable_fails + reset_fails + ack_fails;
    assign req_fire   = mem_req_vld & mem_req_rdy;

    // requests sent but not yet acked
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outstanding <= '0;
        end
        else if (cancel_en) begin
            outstanding <= '0;
        end
        else begin
            case ({req_fire, mem_ack_vld})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

    // ========================================================================
    // protocol properties
    // ========================================================================
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_req_vld && !mem_req_rdy && !cancel_en) |=>
            (mem_req_vld && $stable(mem_req_tag) && $stable(mem_req_addr)))
    else begin
        $error("stalled memory request changed its tag or address or dropped valid");
        stable_fails++;
    end

    a_quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> (!credit_en && !mem_req_vld && !reg_wr_en))
    else begin
        $error("credit, request or writeback active during reset");
        reset_fails++;
    end

    a_ack_has_request: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ack_vld |-> (outstanding != '0))
    else begin
        $error("memory ack arrived with no request outstanding");
        ack_fails++;
    end

endmodule

`default_nettype wire

// ==== test/ldq_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ldq_cfg.svh"

module ldq_tb
    import ldq_pkg::*;
();

    localparam int DEPTH       = `LDQ_DEPTH;
    localparam int MIX_LOADS   = 100;
    localparam int FLUSH_LOADS = 3;
    // two full fills, two random mixes and the flushed loads
    localparam int NUM_LOADS   = 2 * DEPTH + 2 * MIX_LOADS + FLUSH_LOADS;
    localparam int WATCHDOG_NS = (NUM_LOADS * 40 + 200) * 20;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        load_vld;
    mem_addr_t   load_addr;
    load_op_e    load_op;
    reg_idx_t    load_rd;
    logic        cancel_en;
    logic        credit_en;
    logic        mem_req_vld;
    mem_addr_t   mem_req_addr;
    entry_id_t   mem_req_tag;
    logic        mem_req_rdy;
    logic        mem_ack_vld;
    entry_id_t   mem_ack_tag;
    line_data_t  mem_ack_data;
    logic        reg_wr_en;
    reg_idx_t    reg_index;
    reg_val_t    reg_val;

    // scoreboard and memory model state
    logic [31:0] seed = 32'hda7e;
    int          errors = 0;
    mem_addr_t   exp_addr [DEPTH];
    load_op_e    exp_op [DEPTH];
    reg_idx_t    exp_rd [DEPTH];
    logic        acked [DEPTH];
    entry_id_t   pending_q [$];
    entry_id_t   wr_tag;
    entry_id_t   issue_next;
    entry_id_t   head_tag;
    int          credits;
    int          accepted_cnt;
    int          issued_cnt;
    int          credit_cnt;
    int          loads_left;
    int          load_pct;
    int          ack_pct;
    int          rdy_pct;
    logic        expect_idle;

    always #10 clk = ~clk;

    ldq_top UUT (.*);

    bind ldq_top ldq_checker u_checker (
        .clk          (clk),
        .rst_n        (rst_n),
        .cancel_en    (cancel_en),
        .credit_en    (credit_en),
        .mem_req_vld  (mem_req_vld),
        .mem_req_rdy  (mem_req_rdy),
        .mem_req_tag  (mem_req_tag),
        .mem_req_addr (mem_req_addr),
        .mem_ack_vld  (mem_ack_vld),
        .reg_wr_en    (reg_wr_en)
    );

    function automatic logic [15:0] next_random();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    function automatic int percent_roll();
        return int'(next_random()) % 100;
    endfunction

    function automatic line_data_t random_line();
        line_data_t line;
        for (int i = 0; i < `LDQ_LINE_BYTES / 2; i++) begin
            line[i*16 +: 16] = next_random();
        end
        return line;
    endfunction

    // byte lanes past the end of the line read as zero
    function automatic reg_val_t expected_value(input line_data_t line,
                                                input logic [4:0] offset,
                                                input load_op_e op);
        logic [7:0] lane [4];
        int         idx;
        reg_val_t   val;
        for (int i = 0; i < 4; i++) begin
            idx = int'(offset) + i;
            lane[i] = (idx < `LDQ_LINE_BYTES) ? line[idx*8 +: 8] : 8'h00;
        end
        case (op)
            LB:      val = {{24{lane[0][7]}}, lane[0]};
            LBU:     val = {24'h000000, lane[0]};
            LH:      val = {{16{lane[1][7]}}, lane[1], lane[0]};
            LHU:     val = {16'h0000, lane[1], lane[0]};
            default: val = {lane[3], lane[2], lane[1], lane[0]};
        endcase
        return val;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        errors++;
    endtask

    task automatic reset_model();
        wr_tag = '0;
        issue_next = '0;
        head_tag = '0;
        credits = DEPTH;
        accepted_cnt = 0;
        issued_cnt = 0;
        credit_cnt = 0;
        pending_q.delete();
        for (int i = 0; i < DEPTH; i++) begin
            acked[i] = 1'b0;
        end
    endtask

    task automatic set_mode(input int load_p, input int ack_p, input int rdy_p);
        load_pct = load_p;
        ack_pct = ack_p;
        rdy_pct = rdy_p;
    endtask

    // ========================================================================
    // sampling at the rising edge before new inputs are applied
    // ========================================================================
    task automatic check_outputs();
        if (expect_idle) begin
            assert (!mem_req_vld) else report_failure("request raised after cancel with no load");
        end
        if (mem_req_vld && mem_req_rdy) begin
            assert (mem_req_tag == issue_next)
                else report_mismatch("issue order", issue_next, mem_req_tag);
            assert (mem_req_addr == exp_addr[mem_req_tag])
                else report_mismatch("request address", exp_addr[mem_req_tag], mem_req_addr);
            pending_q.push_back(mem_req_tag);
            issue_next = issue_next + 1'b1;
            issued_cnt++;
        end
        // retirement before ack so a same cycle retire is caught
        if (credit_en) begin
            assert (acked[head_tag] && credits < DEPTH)
                else report_failure("credit returned before the head entry was acked");
            acked[head_tag] = 1'b0;
            head_tag = head_tag + 1'b1;
            credits++;
            credit_cnt++;
        end
        if (mem_ack_vld) begin
            assert (reg_wr_en) else report_failure("ack without register write enable");
            assert (reg_index == exp_rd[mem_ack_tag])
                else report_mismatch("writeback index", exp_rd[mem_ack_tag], reg_index);
            assert (reg_val == expected_value(mem_ack_data, exp_addr[mem_ack_tag][4:0],
                                              exp_op[mem_ack_tag]))
                else report_mismatch("writeback value", expected_value(mem_ack_data,
                    exp_addr[mem_ack_tag][4:0], exp_op[mem_ack_tag]), reg_val);
            acked[mem_ack_tag] = 1'b1;
        end
        else begin
            assert (!reg_wr_en) else report_failure("register write enable without an ack");
        end
    endtask

    task automatic drive_inputs();
        mem_addr_t    addr;
        logic [15:0]  r;
        int           pick;
        entry_id_t    tag;
        if (loads_left > 0 && credits > 0 && percent_roll() < load_pct) begin
            addr = {next_random(), next_random()};
            r = next_random();
            exp_addr[wr_tag] = addr;
            exp_op[wr_tag] = load_op_e'(r[2:0]);
            exp_rd[wr_tag] = r[8:3];
            load_vld <= 1'b1;
            load_addr <= addr;
            load_op <= exp_op[wr_tag];
            load_rd <= exp_rd[wr_tag];
            wr_tag = wr_tag + 1'b1;
            credits--;
            loads_left--;
            accepted_cnt++;
            expect_idle = 1'b0;
        end
        else begin
            load_vld <= 1'b0;
        end
        // memory model answers in shuffled order
        if (pending_q.size() > 0 && percent_roll() < ack_pct) begin
            pick = int'(next_random()) % pending_q.size();
            tag = pending_q[pick];
            pending_q.delete(pick);
            mem_ack_vld <= 1'b1;
            mem_ack_tag <= tag;
            mem_ack_data <= random_line();
        end
        else begin
            mem_ack_vld <= 1'b0;
        end
        mem_req_rdy <= (percent_roll() < rdy_pct);
    endtask

    task automatic cycle_step();
        @(posedge clk);
        check_outputs();
        drive_inputs();
    endtask

    task automatic drain();
        while (loads_left > 0 || issued_cnt != accepted_cnt || pending_q.size() > 0) begin
            cycle_step();
        end
        // the last ack may free the head with a full queue behind it
        repeat (DEPTH + 2) cycle_step();
        assert (credit_cnt == accepted_cnt)
            else report_mismatch("credit count", accepted_cnt, credit_cnt);
    endtask

    task automatic fill_queue();
        set_mode(100, 0, 100);
        loads_left = DEPTH;
        while (issued_cnt < DEPTH) begin
            cycle_step();
        end
        assert (credit_cnt == 0) else report_failure("credit returned with no load acked");
        set_mode(0, 60, 100);
        drain();
    endtask

    task automatic cancel_queue();
        @(posedge clk);
        check_outputs();
        load_vld <= 1'b0;
        mem_ack_vld <= 1'b0;
        mem_req_rdy <= 1'b0;
        cancel_en <= 1'b1;
        @(posedge clk);
        check_outputs();
        cancel_en <= 1'b0;
        reset_model();
        expect_idle = 1'b1;
    endtask

    // ========================================================================
    // main sequence
    // ========================================================================
    initial begin
        rst_n = 1'b0;
        load_vld = 1'b0;
        load_addr = '0;
        load_op = LB;
        load_rd = '0;
        cancel_en = 1'b0;
        mem_req_rdy = 1'b0;
        mem_ack_vld = 1'b0;
        mem_ack_tag = '0;
        mem_ack_data = '0;
        expect_idle = 1'b0;
        set_mode(0, 0, 0);
        loads_left = 0;
        reset_model();
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        fill_queue();
        // random mix with back-pressure on the request port
        set_mode(50, 40, 60);
        loads_left = MIX_LOADS;
        drain();

        // a few loads left unrequested and then flushed
        set_mode(100, 0, 0);
        loads_left = FLUSH_LOADS;
        while (loads_left > 0) begin
            cycle_step();
        end
        repeat (3) cycle_step();
        cancel_queue();
        set_mode(0, 0, 100);
        repeat (5) cycle_step();
        fill_queue();

        set_mode(60, 50, 100);
        loads_left = MIX_LOADS;
        drain();

        $display("summary: %0d scoreboard errors, %0d assertion failures",
                 errors, UUT.u_checker.fail_total);
        if (errors == 0 && UUT.u_checker.fail_total == 0) begin
            $display("Finished with no errors");
        end
        else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not complete within %0d ns", WATCHDOG_NS);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire
